// File: verilog.f
+incdir+design
design/rca_pkg.sv
design/grid_xbar_mux.sv
design/grid_io_block.sv
design/grid_pr_slot.sv
design/rca_pr_grid.sv
dv/rca_grid_props.sv
dv/rca_grid_tb.sv

// File: Makefile
.PHONY: all compile run clean

SOURCES = $(wildcard design/*.sv design/*.svh dv/*.sv)

all: run

compile: obj_dir/Vrca_grid_tb

obj_dir/Vrca_grid_tb: verilog.f $(SOURCES)
	verilator --binary --assert --timing -f verilog.f --top-module rca_grid_tb \
		-Mdir obj_dir -o Vrca_grid_tb

run: compile
	./obj_dir/Vrca_grid_tb

clean:
	rm -rf obj_dir

// File: dv/rca_grid_tb.sv
`include "rca_defines.svh"

module rca_grid_tb
    import rca_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS = 20;

    logic                             clk;
    logic                             reset;
    logic [`RCA_XLEN-1:0]             rs_vals [`RCA_NUM_READ_PORTS];
    logic [`RCA_NUM_IO_UNITS-1:0]     rs_data_valid;
    rca_cfg_t                         cfg;
    logic                             io_units_rst;
    logic [`RCA_NUM_IO_UNITS-1:0]     io_fifo_pop;
    grid_word_t                       io_unit_out [`RCA_NUM_IO_UNITS];

    logic [`RCA_XLEN-1:0] op_a [NUM_OPS];
    logic [`RCA_XLEN-1:0] op_b [NUM_OPS];
    logic [`RCA_XLEN-1:0] expected_q [$];
    integer               seed;
    logic                 compare_on;
    int                   watch_unit;

    rca_pr_grid u_rca_pr_grid (
        .clk           (clk),
        .reset         (reset),
        .rs_vals       (rs_vals),
        .rs_data_valid (rs_data_valid),
        .cfg           (cfg),
        .io_units_rst  (io_units_rst),
        .io_fifo_pop   (io_fifo_pop),
        .io_unit_out   (io_unit_out)
    );

    bind grid_io_block rca_grid_props u_props (
        .clk        (clk),
        .reset      (reset),
        .fifo_rst   (fifo_rst),
        .fifo_pop   (fifo_pop),
        .push_req   (push_req),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .data_out   (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [`RCA_XLEN-1:0] apply_op(input slot_op_e op,
                                                     input logic [`RCA_XLEN-1:0] x,
                                                     input logic [`RCA_XLEN-1:0] y);
        case (op)
            op_add:    return x + y;
            op_sub:    return x - y;
            op_and:    return x & y;
            op_or:     return x | y;
            op_xor:    return x ^ y;
            op_pass_a: return x;
            default:   return '0;
        endcase
    endfunction

    // r0 and r1 are the slot results of the row this unit can capture
    function automatic logic [`RCA_XLEN-1:0] io_pick(input rca_cfg_t c, input int k,
                                                    input logic [`RCA_XLEN-1:0] a,
                                                    input logic [`RCA_XLEN-1:0] b,
                                                    input logic [`RCA_XLEN-1:0] r0,
                                                    input logic [`RCA_XLEN-1:0] r1);
        case (c.io_mux_sel[k])
            3'd0:    return a;
            3'd1:    return b;
            3'd2:    return r0;
            3'd3:    return r1;
            3'd4:    return c.io_const[k];
            default: return '0;
        endcase
    endfunction

    // evaluates the configured dataflow from the inputs down to one I/O unit
    function automatic logic [`RCA_XLEN-1:0] reference_result(input rca_cfg_t c,
                                                             input int unit,
                                                             input logic [`RCA_XLEN-1:0] a,
                                                             input logic [`RCA_XLEN-1:0] b);
        logic [`RCA_XLEN-1:0] io_val [2];
        logic [`RCA_XLEN-1:0] slot_val [`RCA_GRID_ROWS][`RCA_GRID_COLS];
        logic [`RCA_XLEN-1:0] cand [`RCA_GRID_MUX_INPUTS];
        int s;
        io_val[0] = io_pick(c, 0, a, b, '0, '0);
        io_val[1] = io_pick(c, 1, a, b, '0, '0);
        for (int i = 0; i < `RCA_GRID_ROWS; i++) begin
            for (int j = 0; j < `RCA_GRID_COLS; j++) begin
                s = i * `RCA_GRID_COLS + j;
                cand[0] = (i > 0) ? slot_val[i-1][0] : '0;
                cand[1] = (i > 0) ? slot_val[i-1][1] : '0;
                cand[2] = io_val[i];
                cand[3] = (j > 0) ? slot_val[i][j-1] : '0;
                slot_val[i][j] = apply_op(c.slot_op[s], cand[c.grid_mux_sel[s]],
                                          cand[c.grid_mux_sel[s + `RCA_NUM_GRID_MUXES]]);
            end
        end
        if (unit < 2) begin
            return io_val[unit];
        end
        return io_pick(c, unit, a, b, slot_val[unit-2][0], slot_val[unit-2][1]);
    endfunction

    task automatic new_operands();
        for (int n = 0; n < NUM_OPS; n++) begin
            op_a[n] = $random(seed);
            op_b[n] = $random(seed);
        end
    endtask

    // second operand trails by one cycle, matching the extra stage on the first path
    task automatic run_stream(input int n, input int out_unit, input int gap);
        int c;
        int step;
        int idx;
        step = gap + 1;
        for (c = 0; c <= n * step; c++) begin
            @(posedge clk);
            #2;
            rs_data_valid = '0;
            if (c % step == 0 && c / step < n) begin
                idx = c / step;
                rs_vals[0] = op_a[idx];
                rs_data_valid[0] = 1'b1;
                expected_q.push_back(reference_result(cfg, out_unit, op_a[idx], op_b[idx]));
            end
            if (c >= 1 && (c - 1) % step == 0 && (c - 1) / step < n) begin
                rs_vals[1] = op_b[(c - 1) / step];
                rs_data_valid[1] = 1'b1;
            end
        end
        @(posedge clk);
        #2;
        rs_data_valid = '0;
    endtask

    task automatic wait_drain(input int unit);
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 200) begin
                $display("timeout: %0d expected words never came out of I/O unit %0d",
                         expected_q.size(), unit);
                fail_run();
            end
        end
        // any extra word shows up here and trips the comparing process
        repeat (4) begin
            @(posedge clk);
            #2;
        end
        check_value($sformatf("io_unit_out[%0d].valid", unit), 32'(io_unit_out[unit].valid), 0);
    endtask

    task automatic wait_valid(input int unit);
        int cycles;
        cycles = 0;
        while (!io_unit_out[unit].valid) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 50) begin
                $display("timeout: no valid output on I/O unit %0d", unit);
                fail_run();
            end
        end
    endtask

    task automatic set_register_path();
        cfg = '0;
        cfg.io_mux_sel[0] = 3'd0;
        cfg.grid_mux_sel[0] = 2'd2;
        cfg.grid_mux_sel[4] = 2'd2;
        cfg.slot_op[0] = op_pass_a;
        cfg.io_mux_sel[2] = 3'd2;
        cfg.io_mode[2] = io_register;
    endtask

    // slot (1,0) combines slot (0,0) above and I/O unit 1
    task automatic set_opcode_path(input slot_op_e op);
        cfg = '0;
        cfg.io_mux_sel[0] = 3'd0;
        cfg.io_mux_sel[1] = 3'd1;
        cfg.grid_mux_sel[0] = 2'd2;
        cfg.grid_mux_sel[4] = 2'd2;
        cfg.slot_op[0] = op_pass_a;
        cfg.grid_mux_sel[2] = 2'd0;
        cfg.grid_mux_sel[6] = 2'd2;
        cfg.slot_op[2] = op;
        cfg.io_mux_sel[3] = 3'd2;
        cfg.io_mode[3] = io_fifo;
    endtask

    task automatic set_deep_path();
        cfg = '0;
        cfg.io_mux_sel[0] = 3'd0;
        cfg.grid_mux_sel[0] = 2'd2;
        cfg.grid_mux_sel[4] = 2'd2;
        cfg.slot_op[0] = op_add;
        cfg.grid_mux_sel[1] = 2'd3;
        cfg.grid_mux_sel[5] = 2'd3;
        cfg.slot_op[1] = op_and;
        cfg.io_mux_sel[1] = 3'd4;
        cfg.io_const[1] = 32'h5a5a_0ff0;
        cfg.grid_mux_sel[2] = 2'd0;
        cfg.grid_mux_sel[6] = 2'd2;
        cfg.slot_op[2] = op_xor;
        // left neighbour and row above both arrive after three registered stages
        cfg.grid_mux_sel[3] = 2'd3;
        cfg.grid_mux_sel[7] = 2'd1;
        cfg.slot_op[3] = op_sub;
        cfg.io_mux_sel[3] = 3'd3;
        cfg.io_mode[3] = io_fifo;
    endtask

    initial begin : compare_outputs
        logic [`RCA_XLEN-1:0] exp_word;
        io_fifo_pop = '0;
        forever begin
            @(posedge clk);
            #2;
            io_fifo_pop = '0;
            if (compare_on && io_unit_out[watch_unit].valid) begin
                if (expected_q.size() == 0) begin
                    $display("unexpected word 0x%08h on I/O unit %0d",
                             io_unit_out[watch_unit].data, watch_unit);
                    fail_run();
                end else begin
                    exp_word = expected_q.pop_front();
                    check_value($sformatf("io_unit_out[%0d].data", watch_unit),
                                io_unit_out[watch_unit].data, exp_word);
                    if (cfg.io_mode[watch_unit] == io_fifo) begin
                        io_fifo_pop[watch_unit] = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        seed = 49;
        reset = 1'b1;
        rs_vals[0] = '0;
        rs_vals[1] = '0;
        rs_data_valid = '0;
        cfg = '0;
        io_units_rst = 1'b0;
        compare_on = 1'b0;
        watch_unit = 0;
        new_operands();
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int k = 0; k < `RCA_NUM_IO_UNITS; k++) begin
            check_value($sformatf("io_unit_out[%0d].valid", k), 32'(io_unit_out[k].valid), 0);
        end

        // spaced words, one valid pulse each
        set_register_path();
        watch_unit = 2;
        compare_on = 1'b1;
        run_stream(6, 2, 2);
        wait_drain(2);

        watch_unit = 3;
        for (int n = 0; n < 6; n++) begin
            set_opcode_path(slot_op_e'(n));
            new_operands();
            run_stream(NUM_OPS, 3, 0);
            wait_drain(3);
        end

        set_deep_path();
        new_operands();
        run_stream(NUM_OPS, 3, 0);
        wait_drain(3);

        // fill the FIFO without popping, then clear it
        set_opcode_path(op_add);
        compare_on = 1'b0;
        run_stream(5, 3, 0);
        wait_valid(3);
        repeat (5) begin
            @(posedge clk);
            #2;
        end
        io_units_rst = 1'b1;
        @(posedge clk);
        #2;
        io_units_rst = 1'b0;
        check_value("io_unit_out[3].valid", 32'(io_unit_out[3].valid), 0);
        expected_q.delete();
        compare_on = 1'b1;
        new_operands();
        run_stream(3, 3, 0);
        wait_drain(3);

        $display("Test OK");
        $finish;
    end

endmodule

// File: dv/rca_grid_props.sv
`include "rca_defines.svh"

module rca_grid_props
    import rca_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       fifo_rst,
    input logic       fifo_pop,
    input logic       push_req,
    input logic       fifo_full,
    input logic       fifo_empty,
    input grid_word_t data_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // the grid has no back-pressure, so a full push loses a word
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) !(push_req && fifo_full)
    ) else $error("push into a full FIFO, word dropped");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) !(fifo_pop && fifo_empty)
    ) else $error("pop on an empty FIFO");

    // clear empties the FIFO and drops the capture register valid
    clear_drops_valid: assert property (
        @(posedge clk) disable iff (reset) fifo_rst |=> !data_out.valid
    ) else $error("output valid still high after FIFO clear");

endmodule

// File: design/rca_pr_grid.sv
`include "rca_defines.svh"

module rca_pr_grid
    import rca_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,

    input  logic [`RCA_XLEN-1:0]             rs_vals [`RCA_NUM_READ_PORTS],
    input  logic [`RCA_NUM_IO_UNITS-1:0]     rs_data_valid,
    input  rca_cfg_t                         cfg,
    input  logic                             io_units_rst,
    input  logic [`RCA_NUM_IO_UNITS-1:0]     io_fifo_pop,
    output grid_word_t                       io_unit_out [`RCA_NUM_IO_UNITS]
);

    localparam int ROWS       = `RCA_GRID_ROWS;
    localparam int COLS       = `RCA_GRID_COLS;
    localparam int NUM_IO     = `RCA_NUM_IO_UNITS;
    localparam int RD_PORTS   = `RCA_NUM_READ_PORTS;
    localparam int IO_INPUTS  = `RCA_IO_MUX_INPUTS;
    localparam int GRID_INPUTS = `RCA_GRID_MUX_INPUTS;

    grid_word_t io_mux_in   [NUM_IO][IO_INPUTS];
    grid_word_t io_mux_out  [NUM_IO];

    // both operand muxes of a slot see the same candidates
    grid_word_t slot_mux_in [ROWS][COLS][GRID_INPUTS];
    grid_word_t slot_in1    [ROWS][COLS];
    grid_word_t slot_in2    [ROWS][COLS];
    grid_word_t slot_out    [ROWS][COLS];

    genvar k, p, c, i, j;

    generate
        for (k = 0; k < NUM_IO; k++) begin : io_mux_inputs
            for (p = 0; p < RD_PORTS; p++) begin : read_ports
                assign io_mux_in[k][p] = '{valid: rs_data_valid[k], data: rs_vals[p]};
            end
            for (c = 0; c < COLS; c++) begin : slot_results
                // units 0 and 1 sit above the grid and see no results
                if (k < 2) begin : no_row
                    assign io_mux_in[k][RD_PORTS + c] = '0;
                end else begin : from_row
                    assign io_mux_in[k][RD_PORTS + c] = slot_out[k - 2][c];
                end
            end
            assign io_mux_in[k][RD_PORTS + COLS] =
                '{valid: rs_data_valid[k], data: cfg.io_const[k]};
        end
    endgenerate

    generate
        for (k = 0; k < NUM_IO; k++) begin : io_units
            grid_xbar_mux #(
                .NUM_INPUTS(IO_INPUTS)
            ) io_mux (
                .data_in  (io_mux_in[k]),
                .data_sel (cfg.io_mux_sel[k]),
                .data_out (io_mux_out[k])
            );

            grid_io_block io_unit (
                .clk         (clk),
                .reset       (reset),
                .data_in     (io_mux_out[k]),
                .output_mode (cfg.io_mode[k]),
                .fifo_rst    (io_units_rst),
                .fifo_pop    (io_fifo_pop[k]),
                .data_out    (io_unit_out[k])
            );
        end
    endgenerate

    generate
        for (i = 0; i < ROWS; i++) begin : slot_mux_row
            for (j = 0; j < COLS; j++) begin : slot_mux_col
                // row above
                for (c = 0; c < COLS; c++) begin : above
                    if (i == 0) begin : top_row
                        assign slot_mux_in[i][j][c] = '0;
                    end else begin : inner_row
                        assign slot_mux_in[i][j][c] = slot_out[i - 1][c];
                    end
                end

                // I/O unit of this row
                assign slot_mux_in[i][j][GRID_INPUTS - 2] = io_unit_out[i];

                // left neighbour
                if (j == 0) begin : left_edge
                    assign slot_mux_in[i][j][GRID_INPUTS - 1] = '0;
                end else begin : left_slot
                    assign slot_mux_in[i][j][GRID_INPUTS - 1] = slot_out[i][j - 1];
                end
            end
        end
    endgenerate

    generate
        for (i = 0; i < ROWS; i++) begin : slots_row
            for (j = 0; j < COLS; j++) begin : slots_col
                grid_xbar_mux #(
                    .NUM_INPUTS(GRID_INPUTS)
                ) mux_a (
                    .data_in  (slot_mux_in[i][j]),
                    .data_sel (cfg.grid_mux_sel[i * COLS + j]),
                    .data_out (slot_in1[i][j])
                );

                grid_xbar_mux #(
                    .NUM_INPUTS(GRID_INPUTS)
                ) mux_b (
                    .data_in  (slot_mux_in[i][j]),
                    .data_sel (cfg.grid_mux_sel[i * COLS + j + `RCA_NUM_GRID_MUXES]),
                    .data_out (slot_in2[i][j])
                );

                grid_pr_slot slot (
                    .clk      (clk),
                    .reset    (reset),
                    .data_in1 (slot_in1[i][j]),
                    .data_in2 (slot_in2[i][j]),
                    .op       (cfg.slot_op[i * COLS + j]),
                    .data_out (slot_out[i][j])
                );
            end
        end
    endgenerate

endmodule

// File: design/grid_pr_slot.sv
`include "rca_defines.svh"

module grid_pr_slot
    import rca_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  grid_word_t data_in1,
    input  grid_word_t data_in2,
    input  slot_op_e   op,
    output grid_word_t data_out
);

    logic [`RCA_XLEN-1:0] result;
    logic                 both_valid;
    logic                 out_valid;
    logic [`RCA_XLEN-1:0] out_data;

    // pass_a also waits for both operands so every opcode has the same timing
    assign both_valid = data_in1.valid && data_in2.valid;

    always_comb begin
        case (op)
            op_add:    result = data_in1.data + data_in2.data;
            op_sub:    result = data_in1.data - data_in2.data;
            op_and:    result = data_in1.data & data_in2.data;
            op_or:     result = data_in1.data | data_in2.data;
            op_xor:    result = data_in1.data ^ data_in2.data;
            op_pass_a: result = data_in1.data;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= both_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (both_valid) begin
            out_data <= result;
        end
    end

    assign data_out.valid = out_valid;
    assign data_out.data  = out_data;

endmodule

// File: design/grid_io_block.sv
`include "rca_defines.svh"

module grid_io_block
    import rca_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  grid_word_t data_in,
    input  io_mode_e   output_mode,
    input  logic       fifo_rst,
    input  logic       fifo_pop,
    output grid_word_t data_out
);

    localparam int DEPTH = `RCA_IO_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // capture register
    logic                 reg_valid;
    logic [`RCA_XLEN-1:0] reg_data;

    // circular FIFO
    logic [`RCA_XLEN-1:0] fifo_mem [DEPTH];
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [CNT_W-1:0]     fifo_count;

    logic fifo_full;
    logic fifo_empty;
    logic push_req;
    logic fifo_push;
    logic fifo_pop_ok;

    assign fifo_full   = (fifo_count == CNT_W'(DEPTH));
    assign fifo_empty  = (fifo_count == '0);
    assign push_req    = data_in.valid && (output_mode == io_fifo);
    // full pushes are dropped and empty pops ignored
    assign fifo_push   = push_req && !fifo_full;
    assign fifo_pop_ok = fifo_pop && !fifo_empty;

    always_ff @(posedge clk) begin
        if (reset || fifo_rst) begin
            reg_valid <= 1'b0;
        end else begin
            reg_valid <= data_in.valid && (output_mode == io_register);
        end
    end

    // data stays after the valid pulse
    always_ff @(posedge clk) begin
        if (data_in.valid && (output_mode == io_register)) begin
            reg_data <= data_in.data;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_push) begin
            fifo_mem[wr_ptr] <= data_in.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || fifo_rst) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (fifo_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({fifo_push, fifo_pop_ok})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // head word is shown whenever the FIFO holds something
    always_comb begin
        if (output_mode == io_fifo) begin
            data_out.valid = !fifo_empty;
            data_out.data  = fifo_mem[rd_ptr];
        end else begin
            data_out.valid = reg_valid;
            data_out.data  = reg_data;
        end
    end

endmodule

// File: design/grid_xbar_mux.sv
module grid_xbar_mux
    import rca_pkg::*;
#(
    parameter int NUM_INPUTS = 4
) (
    input  grid_word_t                        data_in [NUM_INPUTS],
    input  logic [$clog2(NUM_INPUTS)-1:0]     data_sel,
    output grid_word_t                        data_out
);

    // word and valid move together, so one pick covers both
    always_comb begin
        data_out = '0;
        if (int'(data_sel) < NUM_INPUTS) begin
            data_out = data_in[data_sel];
        end
    end

endmodule

// File: design/rca_pkg.sv
`include "rca_defines.svh"

package rca_pkg;

    // ALU operation of a compute slot
    typedef enum logic [2:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,
        op_and    = 3'd2,
        op_or     = 3'd3,
        op_xor    = 3'd4,
        op_pass_a = 3'd5
    } slot_op_e;

    // how an I/O unit presents its captured values
    typedef enum logic {
        io_register = 1'b0,
        io_fifo     = 1'b1
    } io_mode_e;

    // every data path in the grid carries this word
    typedef struct packed {
        logic                 valid;
        logic [`RCA_XLEN-1:0] data;
    } grid_word_t;

    // whole grid configuration, held steady while data moves
    typedef struct packed {
        // one select per I/O unit
        logic [`RCA_NUM_IO_UNITS-1:0][$clog2(`RCA_IO_MUX_INPUTS)-1:0] io_mux_sel;
        io_mode_e [`RCA_NUM_IO_UNITS-1:0] io_mode;
        logic [`RCA_NUM_IO_UNITS-1:0][`RCA_XLEN-1:0] io_const;
        // first operand selects at [slot], second at [slot + NUM_GRID_MUXES]
        logic [2*`RCA_NUM_GRID_MUXES-1:0][$clog2(`RCA_GRID_MUX_INPUTS)-1:0] grid_mux_sel;
        // slot index is row * cols + col
        slot_op_e [`RCA_NUM_GRID_MUXES-1:0] slot_op;
    } rca_cfg_t;

endpackage

// File: design/rca_defines.svh
`ifndef RCA_DEFINES_SVH
`define RCA_DEFINES_SVH

// data word width
`define RCA_XLEN 32

`define RCA_NUM_READ_PORTS 2
`define RCA_GRID_ROWS 2
`define RCA_GRID_COLS 2

// units 0 and 1 feed slot rows, units 2 and 3 capture slot rows 0 and 1
`define RCA_NUM_IO_UNITS (`RCA_GRID_ROWS + 2)

// read ports, one slot row, one constant
`define RCA_IO_MUX_INPUTS (`RCA_NUM_READ_PORTS + `RCA_GRID_COLS + 1)

// row above, own row I/O unit, left neighbour
`define RCA_GRID_MUX_INPUTS (`RCA_GRID_COLS + 2)
`define RCA_NUM_GRID_MUXES (`RCA_GRID_ROWS * `RCA_GRID_COLS)

`define RCA_IO_FIFO_DEPTH 8

`endif
